/* common/window_pkg.sv */
package window_pkg;

  localparam int WIN = 7; // window edge length.

  typedef logic [7:0] pixel_t;

  // r0 is the oldest line, r6 the line currently arriving.
  typedef struct packed {
    pixel_t r0;
    pixel_t r1;
    pixel_t r2;
    pixel_t r3;
    pixel_t r4;
    pixel_t r5;
    pixel_t r6;
  } column_t;

  // c0 is the oldest column, c6 the newest.
  typedef struct packed {
    column_t c0;
    column_t c1;
    column_t c2;
    column_t c3;
    column_t c4;
    column_t c5;
    column_t c6;
  } window_t;

  typedef logic [13:0] sum_t; // 49 * 255 fits in 14 bits.

  typedef enum logic [1:0] {
    MODE_MEAN,
    MODE_MAX,
    MODE_CONTRAST
  } mode_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FRAME,
    ST_DRAIN
  } ctrl_state_e;

  typedef struct packed {
    logic valid;
    logic last;
  } stage_t;

endpackage

/* line_buffer/line_buffer.sv */
`timescale 1ns/1ps

module line_buffer import window_pkg::*; #(
  parameter int MAX_WIDTH = 32
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         wr_en_i,
  input  logic [$clog2(MAX_WIDTH)-1:0] col_idx_i,
  input  pixel_t                       pix_i,
  output column_t                      column_o
);

  localparam int ROWS = WIN - 1;

  // row_mem[0] holds the oldest stored line, row_mem[ROWS-1] the previous one.
  pixel_t row_mem [ROWS][MAX_WIDTH];
  pixel_t rd_pix  [ROWS];

  always_comb begin
    for (int k = 0; k < ROWS; k++) begin
      rd_pix[k] = row_mem[k][col_idx_i];
    end
  end

  assign column_o = {rd_pix[0], rd_pix[1], rd_pix[2], rd_pix[3], rd_pix[4], rd_pix[5], pix_i};

  // the column moves up one line, the oldest pixel drops out.
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      for (int k = 0; k < ROWS - 1; k++) begin
        row_mem[k][col_idx_i] <= rd_pix[k + 1];
      end
      row_mem[ROWS-1][col_idx_i] <= pix_i;
    end
  end

  a_idx_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en_i |-> (32'(col_idx_i) < MAX_WIDTH));

endmodule

/* window/window_datapath.sv */
`timescale 1ns/1ps

module window_datapath import window_pkg::*; #(
  parameter int MAX_WIDTH = 32
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           clear_i,
  input  logic                           accept_i,
  input  logic                           advance_i,
  input  logic [$clog2(MAX_WIDTH+1)-1:0] img_size_i,
  input  column_t                        column_i,
  output logic [$clog2(MAX_WIDTH)-1:0]   col_idx_o,
  output window_t                        window_o,
  output logic                           win_full_o,
  output logic                           last_pix_o
);

  localparam int IDX_W  = $clog2(MAX_WIDTH);
  localparam int SIZE_W = $clog2(MAX_WIDTH + 1);

  logic [SIZE_W-1:0] size_q;
  logic [IDX_W-1:0]  col_q;
  logic [IDX_W-1:0]  row_q;
  logic              col_wrap;
  logic              row_last;
  column_t           col_dly_q;
  logic              dly_vld_q;
  window_t           win_q;

  assign col_wrap = (SIZE_W'(col_q) == size_q - SIZE_W'(1));
  assign row_last = (SIZE_W'(row_q) == size_q - SIZE_W'(1));

  always_ff @(posedge clk) begin
    if (clear_i) begin
      size_q <= img_size_i; // size is taken with the start pulse.
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q <= '0;
      row_q <= '0;
    end else if (clear_i) begin
      col_q <= '0;
      row_q <= '0;
    end else if (accept_i) begin
      if (col_wrap) begin
        col_q <= '0;
        row_q <= row_q + 1'b1;
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  // the delay register holds the column until the window is free to shift.
  always_ff @(posedge clk) begin
    if (accept_i) begin
      col_dly_q <= column_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dly_vld_q <= 1'b0;
    end else if (advance_i) begin
      dly_vld_q <= accept_i;
    end
  end

  always_ff @(posedge clk) begin
    if (advance_i && dly_vld_q) begin
      win_q.c0 <= win_q.c1;
      win_q.c1 <= win_q.c2;
      win_q.c2 <= win_q.c3;
      win_q.c3 <= win_q.c4;
      win_q.c4 <= win_q.c5;
      win_q.c5 <= win_q.c6;
      win_q.c6 <= col_dly_q;
    end
  end

  assign col_idx_o  = col_q;
  assign window_o   = win_q;
  assign win_full_o = (col_q >= IDX_W'(WIN - 1)) && (row_q >= IDX_W'(WIN - 1));
  assign last_pix_o = col_wrap && row_last;

  // input readiness is gated by the output stall in the top level.
  a_no_accept_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
    accept_i |-> advance_i);

endmodule

/* window/window_ctrl.sv */
`timescale 1ns/1ps

module window_ctrl import window_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   start_i,
  input  logic   accept_i,
  input  logic   advance_i,
  input  logic   win_full_i,
  input  logic   last_pix_i,
  input  logic   out_last_i,
  output logic   in_frame_o,
  output logic   clear_o,
  output stage_t stage_o,
  output logic   frame_done_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  stage_t      stage_dly_q;
  stage_t      stage_win_q;
  logic        done_q;
  logic        drain_end;

  assign clear_o   = (state_q == ST_IDLE) && start_i;
  assign drain_end = (state_q == ST_DRAIN) && out_last_i && advance_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE:  if (start_i) state_d = ST_FRAME;
      ST_FRAME: if (accept_i && last_pix_i) state_d = ST_DRAIN;
      ST_DRAIN: if (drain_end) state_d = ST_IDLE;
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= drain_end;
    end
  end

  // two stages follow the delay and window registers of the datapath.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage_dly_q <= '0;
      stage_win_q <= '0;
    end else if (advance_i) begin
      stage_dly_q.valid <= accept_i && win_full_i;
      stage_dly_q.last  <= accept_i && last_pix_i;
      stage_win_q       <= stage_dly_q;
    end
  end

  assign in_frame_o   = (state_q == ST_FRAME);
  assign stage_o      = stage_win_q;
  assign frame_done_o = done_q;

  a_start_ignored: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == ST_FRAME && start_i && !(accept_i && last_pix_i)) |=> state_q == ST_FRAME);

endmodule

/* design/box_sum.sv */
`timescale 1ns/1ps

module box_sum import window_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    advance_i,
  input  window_t window_i,
  input  stage_t  stage_i,
  output sum_t    sum_o,
  output stage_t  stage_o
);

  localparam int NPIX   = WIN * WIN;
  localparam int LEAVES = 2 ** $clog2(NPIX);

  pixel_t [NPIX-1:0] pix;
  sum_t              node [LEAVES];

  assign pix = window_i;

  always_comb begin
    for (int i = 0; i < LEAVES; i++) begin
      node[i] = (i < NPIX) ? sum_t'(pix[i]) : '0;
    end
    // each pass adds neighbour pairs in place and halves the live width.
    for (int w = LEAVES / 2; w > 0; w = w / 2) begin
      for (int i = 0; i < w; i++) begin
        node[i] = node[2*i] + node[2*i+1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum_o   <= '0;
      stage_o <= '0;
    end else if (advance_i) begin
      sum_o   <= node[0];
      stage_o <= stage_i;
    end
  end

endmodule

/* design/window_max.sv */
`timescale 1ns/1ps

module window_max import window_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    advance_i,
  input  window_t window_i,
  output pixel_t  max_o
);

  localparam int NPIX   = WIN * WIN;
  localparam int LEAVES = 2 ** $clog2(NPIX);

  pixel_t [NPIX-1:0] pix;
  pixel_t            node [LEAVES];

  assign pix = window_i;

  always_comb begin
    for (int i = 0; i < LEAVES; i++) begin
      node[i] = (i < NPIX) ? pix[i] : '0; // zero padding never wins.
    end
    for (int w = LEAVES / 2; w > 0; w = w / 2) begin
      for (int i = 0; i < w; i++) begin
        node[i] = (node[2*i] > node[2*i+1]) ? node[2*i] : node[2*i+1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      max_o <= '0;
    end else if (advance_i) begin
      max_o <= node[0];
    end
  end

endmodule

/* design/result_combine.sv */
`timescale 1ns/1ps

module result_combine import window_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   advance_i,
  input  mode_e  mode_i,
  input  sum_t   sum_i,
  input  pixel_t max_i,
  input  stage_t stage_i,
  output logic   res_valid_o,
  output pixel_t res_data_o,
  output logic   res_last_o
);

  // 1338 / 65536 is close to 1 / 49.
  localparam int MEAN_MUL   = 1338;
  localparam int MEAN_SHIFT = 16;

  logic [24:0] product;
  logic [8:0]  mean_wide;
  pixel_t      mean;
  pixel_t      contrast;
  pixel_t      result;

  assign product   = sum_i * 25'(MEAN_MUL);
  assign mean_wide = 9'(product >> MEAN_SHIFT);
  assign mean      = mean_wide[7:0];
  assign contrast  = (max_i > mean) ? max_i - mean : '0;

  always_comb begin
    unique case (mode_i)
      MODE_MAX:      result = max_i;
      MODE_CONTRAST: result = contrast;
      default:       result = mean;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid_o <= 1'b0;
      res_last_o  <= 1'b0;
    end else if (advance_i) begin
      res_valid_o <= stage_i.valid;
      res_last_o  <= stage_i.last;
    end
  end

  always_ff @(posedge clk) begin
    if (advance_i) begin
      res_data_o <= result;
    end
  end

  a_mean_fits: assert property (@(posedge clk) disable iff (!rst_n)
    stage_i.valid |-> (mean_wide <= 9'd255));

endmodule

/* design/window_filter_top.sv */
`timescale 1ns/1ps

module window_filter_top import window_pkg::*; #(
  parameter int MAX_WIDTH = 32
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           start_i,
  input  logic [$clog2(MAX_WIDTH+1)-1:0] img_size_i,
  input  mode_e                          mode_i,
  input  logic                           pix_valid_i,
  input  pixel_t                         pix_data_i,
  output logic                           pix_ready_o,
  output logic                           res_valid_o,
  output pixel_t                         res_data_o,
  input  logic                           res_ready_i,
  output logic                           frame_done_o
);

  localparam int IDX_W = $clog2(MAX_WIDTH);

  logic             advance;
  logic             accept;
  logic             in_frame;
  logic             clear;
  logic [IDX_W-1:0] col_idx;
  column_t          column;
  window_t          window;
  logic             win_full;
  logic             last_pix;
  stage_t           stage_win;
  stage_t           stage_sum;
  sum_t             sum;
  pixel_t           max_val;
  mode_e            mode_q;
  logic             res_last;

  // every stage moves only when the output register can take a new value.
  assign advance     = !res_valid_o || res_ready_i;
  assign pix_ready_o = in_frame && advance;
  assign accept      = pix_valid_i && pix_ready_o;

  always_ff @(posedge clk) begin
    if (clear) begin
      mode_q <= mode_i;
    end
  end

  line_buffer #(.MAX_WIDTH(MAX_WIDTH)) u_line_buffer (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_en_i   (accept),
    .col_idx_i (col_idx),
    .pix_i     (pix_data_i),
    .column_o  (column)
  );

  window_datapath #(.MAX_WIDTH(MAX_WIDTH)) u_window_datapath (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear_i    (clear),
    .accept_i   (accept),
    .advance_i  (advance),
    .img_size_i (img_size_i),
    .column_i   (column),
    .col_idx_o  (col_idx),
    .window_o   (window),
    .win_full_o (win_full),
    .last_pix_o (last_pix)
  );

  window_ctrl u_window_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .accept_i     (accept),
    .advance_i    (advance),
    .win_full_i   (win_full),
    .last_pix_i   (last_pix),
    .out_last_i   (res_last),
    .in_frame_o   (in_frame),
    .clear_o      (clear),
    .stage_o      (stage_win),
    .frame_done_o (frame_done_o)
  );

  box_sum u_box_sum (
    .clk       (clk),
    .rst_n     (rst_n),
    .advance_i (advance),
    .window_i  (window),
    .stage_i   (stage_win),
    .sum_o     (sum),
    .stage_o   (stage_sum)
  );

  window_max u_window_max (
    .clk       (clk),
    .rst_n     (rst_n),
    .advance_i (advance),
    .window_i  (window),
    .max_o     (max_val)
  );

  result_combine u_result_combine (
    .clk         (clk),
    .rst_n       (rst_n),
    .advance_i   (advance),
    .mode_i      (mode_q),
    .sum_i       (sum),
    .max_i       (max_val),
    .stage_i     (stage_sum),
    .res_valid_o (res_valid_o),
    .res_data_o  (res_data_o),
    .res_last_o  (res_last)
  );

endmodule

/* sim/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker import window_pkg::*; #(
  parameter int MAX_WIDTH = 32
) (
  input logic                           clk,
  input logic                           rst_n,
  input logic                           start_i,
  input logic [$clog2(MAX_WIDTH+1)-1:0] img_size_i,
  input mode_e                          mode_i,
  input logic                           pix_valid_i,
  input pixel_t                         pix_data_i,
  input logic                           pix_ready_i,
  input logic                           res_valid_i,
  input pixel_t                         res_data_i,
  input logic                           res_ready_i,
  input logic                           frame_done_i,
  input ctrl_state_e                    state_i
);

  localparam int LATENCY = 4; // delay, window, sum and max, combine.

  pixel_t img [MAX_WIDTH][MAX_WIDTH];
  int     exp_val_q [$];
  int     exp_cyc_q [$];
  int     exp_stall_q [$];
  int     size;
  mode_e  mode;
  int     col;
  int     row;
  int     results;
  int     test_idx     = 0;
  int     test_errors  = 0;
  bit     in_test      = 1'b0;
  int     cycle        = 0;
  int     stall_cnt    = 0;
  bit     hold_q       = 1'b0;
  pixel_t held_data;
  int     error_count  = 0;
  int     tests_passed = 0;
  int     tests_failed = 0;

  task automatic report_mismatch(input string msg);
    $display("error @%0t: %s", $time, msg);
    error_count++;
    test_errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    error_count++;
    test_errors++;
  endtask

  // r and c give the bottom right pixel of the window.
  function automatic int window_result(input int r, input int c);
    int sum;
    int mx;
    int mean;
    int v;
    sum = 0;
    mx  = 0;
    for (int dr = 0; dr < WIN; dr++) begin
      for (int dc = 0; dc < WIN; dc++) begin
        v = int'(img[r-dr][c-dc]);
        sum += v;
        if (v > mx) begin
          mx = v;
        end
      end
    end
    mean = (sum * 1338) >> 16;
    case (mode)
      MODE_MAX:      return mx;
      MODE_CONTRAST: return (mx > mean) ? mx - mean : 0;
      default:       return mean;
    endcase
  endfunction

  task automatic open_test();
    size        = int'(img_size_i);
    mode        = mode_i;
    col         = 0;
    row         = 0;
    results     = 0;
    test_errors = 0;
    in_test     = 1'b1;
    test_idx++;
    exp_val_q.delete();
    exp_cyc_q.delete();
    exp_stall_q.delete();
  endtask

  task automatic take_pixel();
    if (!in_test || row >= size) begin
      report_failure("a pixel was accepted outside of a running frame");
    end else begin
      img[row][col] = pix_data_i;
      if (row >= WIN - 1 && col >= WIN - 1) begin
        exp_val_q.push_back(window_result(row, col));
        exp_cyc_q.push_back(cycle);
        exp_stall_q.push_back(stall_cnt);
      end
      col++;
      if (col == size) begin
        col = 0;
        row++;
      end
    end
  endtask

  task automatic check_result();
    int expected;
    int lat;
    int want_lat;
    if (exp_val_q.size() == 0) begin
      report_failure($sformatf("an extra result %0d came out with no window pending",
                               res_data_i));
    end else begin
      expected = exp_val_q.pop_front();
      lat      = cycle - exp_cyc_q.pop_front();
      want_lat = LATENCY + stall_cnt - exp_stall_q.pop_front(); // stalls freeze every stage.
      if (int'(res_data_i) != expected) begin
        report_mismatch($sformatf("result %0d is %0d, expected %0d",
                                  results, res_data_i, expected));
      end
      if (lat != want_lat) begin
        report_mismatch($sformatf("result %0d took %0d cycles, expected %0d",
                                  results, lat, want_lat));
      end
      results++;
    end
  endtask

  task automatic close_test();
    int want;
    if (!in_test) begin
      report_failure("frame_done_o pulsed while no frame was running");
    end else begin
      want = (size - (WIN - 1)) * (size - (WIN - 1));
      if (results != want || exp_val_q.size() != 0) begin
        report_failure($sformatf("test %0d ended with %0d results where %0d were expected",
                                 test_idx, results, want));
      end
      if (test_errors == 0) begin
        tests_passed++;
      end else begin
        tests_failed++;
      end
      $display("test %0d: size %0d, mode %s, %0d results, %s", test_idx, size,
               mode.name(), results, (test_errors == 0) ? "ok" : "FAILED");
      in_test = 1'b0;
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      cycle++;
      if (res_valid_i && !res_ready_i) begin
        stall_cnt++;
      end
      if (!in_test && (pix_ready_i || res_valid_i)) begin
        report_mismatch($sformatf("stream handshake active between frames in state %s",
                                  state_i.name()));
      end
      if (hold_q && (!res_valid_i || res_data_i != held_data)) begin
        report_mismatch("output changed while res_ready_i was low");
      end
      hold_q    = res_valid_i && !res_ready_i;
      held_data = res_data_i;
      if (start_i && !in_test) begin
        open_test();
      end
      if (pix_valid_i && pix_ready_i) begin
        take_pixel();
      end
      if (res_valid_i && res_ready_i) begin
        check_result();
      end
      if (frame_done_i) begin
        close_test();
      end
    end
  end

endmodule

/* sim/tb_top.sv */
`timescale 1ns/1ps

module tb_top import window_pkg::*; ();

  localparam int MAX_WIDTH = 32;
  localparam int SIZE_W    = $clog2(MAX_WIDTH + 1);
  localparam int NUM_TESTS = 7;
  localparam int MARGIN    = 2000;

  typedef enum logic [1:0] {
    PAT_CONST,
    PAT_RAMP,
    PAT_LFSR
  } pattern_e;

  typedef struct packed {
    int       size;
    mode_e    mode;
    pattern_e pattern;
    logic     backpressure; // also opens random gaps in the input stream.
  } test_t;

  test_t tests [NUM_TESTS] = '{
    '{8,  MODE_MAX,      PAT_CONST, 1'b0},
    '{10, MODE_MEAN,     PAT_RAMP,  1'b0},
    '{7,  MODE_CONTRAST, PAT_LFSR,  1'b0},
    '{12, MODE_CONTRAST, PAT_LFSR,  1'b1},
    '{32, MODE_CONTRAST, PAT_LFSR,  1'b0},
    '{16, MODE_MEAN,     PAT_LFSR,  1'b1},
    '{32, MODE_MAX,      PAT_RAMP,  1'b1}
  };

  logic              clk;
  logic              rst_n;
  logic              start;
  logic [SIZE_W-1:0] img_size;
  mode_e             mode;
  logic              pix_valid;
  pixel_t            pix_data;
  logic              pix_ready;
  logic              res_valid;
  pixel_t            res_data;
  logic              res_ready;
  logic              frame_done;

  logic [31:0] lfsr_state = 32'hda6bcd26;
  pixel_t      frame_pix [MAX_WIDTH*MAX_WIDTH];
  int          cycle_count = 0;
  int          cycle_limit;

  window_filter_top #(.MAX_WIDTH(MAX_WIDTH)) DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start),
    .img_size_i   (img_size),
    .mode_i       (mode),
    .pix_valid_i  (pix_valid),
    .pix_data_i   (pix_data),
    .pix_ready_o  (pix_ready),
    .res_valid_o  (res_valid),
    .res_data_o   (res_data),
    .res_ready_i  (res_ready),
    .frame_done_o (frame_done)
  );

  tb_checker #(.MAX_WIDTH(MAX_WIDTH)) u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start),
    .img_size_i   (img_size),
    .mode_i       (mode),
    .pix_valid_i  (pix_valid),
    .pix_data_i   (pix_data),
    .pix_ready_i  (pix_ready),
    .res_valid_i  (res_valid),
    .res_data_i   (res_data),
    .res_ready_i  (res_ready),
    .frame_done_i (frame_done),
    .state_i      (DUT.u_window_ctrl.state_q)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | int'(lfsr_state[0]);
    end
    return v;
  endfunction

  task automatic build_frame(input test_t t);
    for (int r = 0; r < t.size; r++) begin
      for (int c = 0; c < t.size; c++) begin
        case (t.pattern)
          PAT_CONST: frame_pix[r*t.size+c] = 8'd173;
          PAT_RAMP:  frame_pix[r*t.size+c] = pixel_t'((r + c) % 256);
          default:   frame_pix[r*t.size+c] = pixel_t'(take_bits(8));
        endcase
      end
    end
  endtask

  task automatic run_test(input test_t t);
    int n;
    int p;
    bit done;
    bit poked;
    bit took;
    n     = t.size * t.size;
    p     = 0;
    done  = 1'b0;
    poked = 1'b0;
    took  = 1'b0;
    build_frame(t);
    @(posedge clk);
    start    <= 1'b1;
    img_size <= SIZE_W'(t.size);
    mode     <= t.mode;
    @(posedge clk);
    while (!done) begin
      start <= 1'b0;
      if (!poked && p >= n / 2) begin
        start    <= 1'b1; // the controller is busy, so this must change nothing.
        img_size <= SIZE_W'(9);
        mode     <= MODE_MEAN;
        poked    = 1'b1;
      end
      if (p >= n) begin
        pix_valid <= 1'b0;
      end else if (!pix_valid || took) begin
        pix_valid <= t.backpressure ? (take_bits(2) != 0) : 1'b1;
        pix_data  <= frame_pix[p];
      end
      res_ready <= t.backpressure ? (take_bits(2) != 0) : 1'b1;
      @(posedge clk);
      took = pix_valid && pix_ready;
      if (took) begin
        p++;
      end
      done = frame_done;
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    rst_n     = 1'b0;
    start     = 1'b0;
    img_size  = '0;
    mode      = MODE_MEAN;
    pix_valid = 1'b0;
    pix_data  = '0;
    res_ready = 1'b0;
    cycle_limit = MARGIN;
    foreach (tests[i]) begin
      cycle_limit += 4 * tests[i].size * tests[i].size;
    end
    repeat (3) @(posedge clk);
    rst_n     <= 1'b1;
    res_ready <= 1'b1;
    repeat (2) @(posedge clk);
    foreach (tests[i]) begin
      run_test(tests[i]);
    end
    repeat (5) @(posedge clk);
    $display("tests passed %0d, tests failed %0d, check errors %0d",
             u_checker.tests_passed, u_checker.tests_failed, u_checker.error_count);
    if (u_checker.error_count == 0 && u_checker.tests_passed == NUM_TESTS) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* project.f */
common/window_pkg.sv
line_buffer/line_buffer.sv
window/window_datapath.sv
window/window_ctrl.sv
design/box_sum.sv
design/window_max.sv
design/result_combine.sv
design/window_filter_top.sv
sim/tb_checker.sv
sim/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
RTL_TOP   ?= window_filter_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
